//--- design/ofdm_defs.svh
`ifndef OFDM_DEFS_SVH
`define OFDM_DEFS_SVH

`define OFDM_NFFT_W      5      // log2 fft size
`define OFDM_NSC_W       16     // subcarrier count and index
`define OFDM_BIN_W       12     // bin index, up to 4096 bins
`define OFDM_SCALE_W     12     // six 2-bit stage shifts
`define OFDM_BW_W        4      // channel bandwidth code

// channel bandwidth codes
`define BW_20M           4'd0
`define BW_10M           4'd1
`define BW_5M            4'd2
`define BW_15M           4'd3
`define BW_NR100         4'd4

`define SCALE_DEFAULT    12'b00_01_01_01_01_10  // all bandwidths but 5 MHz fwd
`define SCALE_5M         12'b00_00_01_01_01_10  // 5 MHz, forward fft only

// reset config is the 20 MHz entry
`define CFG_DEFAULT_NFFT 11
`define CFG_DEFAULT_NSC  1200

`endif

//--- design/ofdm_pkg.sv
`include "ofdm_defs.svh"

package ofdm_pkg;

    typedef logic [`OFDM_NFFT_W-1:0]  nfft_t;   // log2 of fft size
    typedef logic [`OFDM_NSC_W-1:0]   nsc_t;    // subcarrier count or index
    typedef logic [`OFDM_BIN_W-1:0]   bin_t;    // fft bin number
    typedef logic [`OFDM_SCALE_W-1:0] scale_t;  // fft stage scaling schedule
    typedef logic [`OFDM_BW_W-1:0]    bw_t;     // channel bandwidth code

    // bandwidth update sequencer
    typedef enum logic [1:0] {
        upd_idle,       // waiting for carrier enable edge
        upd_nfft_we,    // issue fft size write
        upd_ctrl_we     // issue control write, latch bandwidth
    } upd_state_t;

    // word handed to the fft core
    typedef struct packed {
        logic   fwd_inv;    // 1 forward, 0 inverse
        scale_t scale_sch;
        nfft_t  nfft;
    } fft_cfg_t;

    // active config as seen by the mapper
    typedef struct packed {
        nfft_t nfft;
        nsc_t  nsc;
    } map_cfg_t;

    // one bin of the symbol sweep
    typedef struct packed {
        bin_t bin;
        logic occupied;     // data subcarrier, not guard or dc
        nsc_t sc_index;     // data index, 0 when unoccupied
        logic first;        // bin 0
        logic last;         // bin N-1
    } bin_info_t;

endpackage

//--- design/bw_update_ctrl.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module bw_update_ctrl #(
    parameter bit is_fft = 1'b1                     // 1 forward fft, 0 inverse
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_en,
    input  logic                car_en,             // carrier enable level
    input  ofdm_pkg::bw_t       ch_bw,              // requested bandwidth code
    output ofdm_pkg::nfft_t     nfft_size,          // looked-up log2 fft size
    output ofdm_pkg::nsc_t      nsc,                // looked-up subcarrier count
    output ofdm_pkg::scale_t    scale_sch,          // looked-up scaling schedule
    output logic                nfft_we,            // commit nfft_size
    output logic                ctrl_we,            // commit nsc and scale_sch
    output logic                update_done,        // new config word valid
    output ofdm_pkg::bw_t       current_ch_bw       // bandwidth now in effect
);

    logic                 car_en_d;     // car_en one enabled cycle ago
    logic                 car_en_rise;
    logic                 done_pre;     // done before the extra delay stage
    ofdm_pkg::upd_state_t state;
    ofdm_pkg::upd_state_t state_nxt;

    assign car_en_rise = car_en & ~car_en_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            car_en_d <= 1'b0;
        end else if (clk_en) begin
            car_en_d <= car_en;                 // edge detect history
        end
    end

    // table lookup, registered, follows ch_bw by one enabled cycle
    always_ff @(posedge clk) begin
        if (clk_en) begin
            case (ch_bw)
                `BW_20M: begin
                    nfft_size <= ofdm_pkg::nfft_t'(11);
                    nsc       <= ofdm_pkg::nsc_t'(1200);
                end
                `BW_10M: begin
                    nfft_size <= ofdm_pkg::nfft_t'(10);
                    nsc       <= ofdm_pkg::nsc_t'(600);
                end
                `BW_5M: begin
                    nfft_size <= ofdm_pkg::nfft_t'(9);
                    nsc       <= ofdm_pkg::nsc_t'(300);
                end
                `BW_15M: begin
                    nfft_size <= ofdm_pkg::nfft_t'(11);  // shares 2048 with 20 MHz
                    nsc       <= ofdm_pkg::nsc_t'(900);
                end
                `BW_NR100: begin
                    nfft_size <= ofdm_pkg::nfft_t'(12);  // nr 100 MHz
                    nsc       <= ofdm_pkg::nsc_t'(3276);
                end
                default: begin
                    nfft_size <= ofdm_pkg::nfft_t'(`CFG_DEFAULT_NFFT);
                    nsc       <= ofdm_pkg::nsc_t'(`CFG_DEFAULT_NSC);
                end
            endcase
            // 5 MHz forward path uses a lighter schedule
            if (is_fft && (ch_bw == `BW_5M)) begin
                scale_sch <= `SCALE_5M;
            end else begin
                scale_sch <= `SCALE_DEFAULT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ofdm_pkg::upd_idle;
        end else if (clk_en) begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ofdm_pkg::upd_idle: begin
                if (car_en_rise) begin
                    state_nxt = ofdm_pkg::upd_nfft_we;   // only idle sees edges
                end
            end
            ofdm_pkg::upd_nfft_we: state_nxt = ofdm_pkg::upd_ctrl_we;
            ofdm_pkg::upd_ctrl_we: state_nxt = ofdm_pkg::upd_idle;
            default:               state_nxt = ofdm_pkg::upd_idle;
        endcase
    end

    // strobes registered from state, one enabled cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            nfft_we       <= 1'b0;
            ctrl_we       <= 1'b0;
            done_pre      <= 1'b0;
            update_done   <= 1'b0;
            current_ch_bw <= '0;
        end else if (clk_en) begin
            nfft_we     <= (state == ofdm_pkg::upd_nfft_we);
            ctrl_we     <= (state == ofdm_pkg::upd_ctrl_we);
            done_pre    <= (state == ofdm_pkg::upd_ctrl_we);
            update_done <= done_pre;            // lands after ctrl commit
            if (state == ofdm_pkg::upd_ctrl_we) begin
                current_ch_bw <= ch_bw;
            end
        end
    end

endmodule

//--- design/fft_cfg_regs.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module fft_cfg_regs #(
    parameter bit is_fft = 1'b1                     // drives fwd_inv
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_en,
    input  ofdm_pkg::nfft_t      nfft_size,         // from lookup
    input  ofdm_pkg::nsc_t       nsc,
    input  ofdm_pkg::scale_t     scale_sch,
    input  logic                 nfft_we,           // step 1 of commit
    input  logic                 ctrl_we,           // step 2 of commit
    output ofdm_pkg::fft_cfg_t   fft_cfg,           // fft core config word
    output ofdm_pkg::map_cfg_t   map_cfg            // mapper config
);

    ofdm_pkg::nfft_t  nfft_q;     // active log2 fft size
    ofdm_pkg::nsc_t   nsc_q;      // active occupied subcarriers
    ofdm_pkg::scale_t scale_q;    // active scaling schedule

    // fft size goes first, so the word is half updated for one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            nfft_q <= ofdm_pkg::nfft_t'(`CFG_DEFAULT_NFFT);
        end else if (clk_en && nfft_we) begin
            nfft_q <= nfft_size;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nsc_q   <= ofdm_pkg::nsc_t'(`CFG_DEFAULT_NSC);
            scale_q <= `SCALE_DEFAULT;
        end else if (clk_en && ctrl_we) begin
            nsc_q   <= nsc;                     // completes the commit
            scale_q <= scale_sch;
        end
    end

    assign fft_cfg.fwd_inv   = is_fft;
    assign fft_cfg.scale_sch = scale_q;
    assign fft_cfg.nfft      = nfft_q;

    assign map_cfg.nfft = nfft_q;
    assign map_cfg.nsc  = nsc_q;

endmodule

//--- design/sc_mapper.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module sc_mapper (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_en,
    input  logic                 sym_start,         // begin one symbol sweep
    input  ofdm_pkg::map_cfg_t   map_cfg,           // active config
    output logic                 bin_valid,         // high for each swept bin
    output ofdm_pkg::bin_info_t  bin_info
);

    localparam int size_w = `OFDM_BIN_W + 1;   // fft size needs one extra bit at 4096

    logic [size_w-1:0] size_cfg;    // N from live config
    ofdm_pkg::nsc_t    half_cfg;    // h from live config
    ofdm_pkg::bin_t    upper_cfg;   // first bin of upper band, N-h
    ofdm_pkg::bin_t    last_cfg;    // N-1
    ofdm_pkg::nsc_t    half_lat;    // held for the sweep
    ofdm_pkg::bin_t    upper_lat;
    ofdm_pkg::bin_t    last_lat;
    ofdm_pkg::nsc_t    half_sel;    // values for the bin being computed
    ofdm_pkg::bin_t    upper_sel;
    ofdm_pkg::bin_t    last_sel;
    ofdm_pkg::bin_t    bin_nxt;     // bin to present next
    logic              start;
    logic              at_last;     // presenting the final bin
    logic              advance;     // present a new bin this cycle
    logic              occ_lo;      // bins 1..h
    logic              occ_hi;      // bins N-h..N-1
    ofdm_pkg::nsc_t    idx_nxt;

    assign size_cfg  = size_w'(1) << map_cfg.nfft;
    assign half_cfg  = map_cfg.nsc >> 1;
    assign upper_cfg = ofdm_pkg::bin_t'(size_cfg - size_w'(half_cfg));
    assign last_cfg  = ofdm_pkg::bin_t'(size_cfg - size_w'(1));

    assign start   = sym_start & ~bin_valid;           // ignored mid sweep
    assign at_last = bin_valid & (bin_info.bin == last_lat);
    assign advance = start | (bin_valid & ~at_last);

    // first bin uses live config, the rest use the latched copy
    assign half_sel  = start ? half_cfg  : half_lat;
    assign upper_sel = start ? upper_cfg : upper_lat;
    assign last_sel  = start ? last_cfg  : last_lat;
    assign bin_nxt   = start ? '0 : bin_info.bin + ofdm_pkg::bin_t'(1);

    // bin 0 is dc, excluded from both bands
    assign occ_lo = (bin_nxt != '0) && (ofdm_pkg::nsc_t'(bin_nxt) <= half_sel);
    assign occ_hi = (bin_nxt != '0) && (bin_nxt >= upper_sel);

    always_comb begin
        if (occ_lo) begin
            idx_nxt = half_sel + ofdm_pkg::nsc_t'(bin_nxt) - ofdm_pkg::nsc_t'(1);
        end else if (occ_hi) begin
            idx_nxt = ofdm_pkg::nsc_t'(bin_nxt - upper_sel);  // negative freqs first
        end else begin
            idx_nxt = '0;                       // guard or dc
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bin_valid <= 1'b0;
        end else if (clk_en) begin
            if (start) begin
                bin_valid <= 1'b1;
            end else if (at_last) begin
                bin_valid <= 1'b0;              // sweep finished
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && start) begin
            half_lat  <= half_cfg;              // freeze config for the symbol
            upper_lat <= upper_cfg;
            last_lat  <= last_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && advance) begin
            bin_info.bin      <= bin_nxt;
            bin_info.occupied <= occ_lo | occ_hi;
            bin_info.sc_index <= idx_nxt;
            bin_info.first    <= (bin_nxt == '0);
            bin_info.last     <= (bin_nxt == last_sel);
        end
    end

endmodule

//--- design/ofdm_bw_top.sv
`timescale 1ns/1ps

module ofdm_bw_top #(
    parameter bit is_fft = 1'b1                     // 1 forward fft, 0 inverse
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clk_en,
    input  logic                 car_en,
    input  ofdm_pkg::bw_t        ch_bw,
    input  logic                 sym_start,
    output ofdm_pkg::fft_cfg_t   fft_cfg,
    output logic                 update_done,
    output ofdm_pkg::bw_t        current_ch_bw,
    output logic                 bin_valid,
    output ofdm_pkg::bin_info_t  bin_info
);

    ofdm_pkg::nfft_t    nfft_size;    // lookup to register bank
    ofdm_pkg::nsc_t     nsc;
    ofdm_pkg::scale_t   scale_sch;
    logic               nfft_we;
    logic               ctrl_we;
    ofdm_pkg::map_cfg_t map_cfg;      // active config to mapper

    bw_update_ctrl #(.is_fft(is_fft)) u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .clk_en        (clk_en),
        .car_en        (car_en),
        .ch_bw         (ch_bw),
        .nfft_size     (nfft_size),
        .nsc           (nsc),
        .scale_sch     (scale_sch),
        .nfft_we       (nfft_we),
        .ctrl_we       (ctrl_we),
        .update_done   (update_done),
        .current_ch_bw (current_ch_bw)
    );

    fft_cfg_regs #(.is_fft(is_fft)) u_regs (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .nfft_size (nfft_size),
        .nsc       (nsc),
        .scale_sch (scale_sch),
        .nfft_we   (nfft_we),
        .ctrl_we   (ctrl_we),
        .fft_cfg   (fft_cfg),
        .map_cfg   (map_cfg)
    );

    sc_mapper u_mapper (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .sym_start (sym_start),
        .map_cfg   (map_cfg),
        .bin_valid (bin_valid),
        .bin_info  (bin_info)
    );

endmodule

//--- dv/ofdm_bw_tb.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module ofdm_bw_tb;

    localparam int timeout_cycles = 40000;    // 6 updates + 6 sweeps at 3/4 enable rate

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      clk_en;
    logic                      car_en;
    ofdm_pkg::bw_t             ch_bw;
    logic                      sym_start;
    ofdm_pkg::fft_cfg_t        fft_cfg;
    logic                      update_done;
    ofdm_pkg::bw_t             current_ch_bw;
    logic                      bin_valid;
    ofdm_pkg::bin_info_t       bin_info;

    int errors = 0;
    int cycles = 0;
    int updates_done = 0;
    int sweeps_done = 0;

    // reference model state updated on enabled edges
    int                 phase;          // enabled edges since E0, 0 when idle
    logic               car_prev;
    ofdm_pkg::bw_t      code_lat;
    logic               exp_done;
    ofdm_pkg::bw_t      exp_bw;
    ofdm_pkg::nfft_t    exp_nfft;
    ofdm_pkg::nsc_t     exp_nsc;
    ofdm_pkg::scale_t   exp_scale;
    logic               exp_valid;
    int                 exp_bin;
    logic               exp_occ;
    ofdm_pkg::nsc_t     exp_idx;
    logic               exp_first;
    logic               exp_last;
    int                 sweep_n;        // N frozen at sweep start
    int                 sweep_nsc;

    // sweep audit
    bit seen [0:4095];
    int occ_count;
    int bin_count;

    ofdm_bw_top #(.is_fft(1'b1)) DUT (
        .clk           (clk),
        .reset         (reset),
        .clk_en        (clk_en),
        .car_en        (car_en),
        .ch_bw         (ch_bw),
        .sym_start     (sym_start),
        .fft_cfg       (fft_cfg),
        .update_done   (update_done),
        .current_ch_bw (current_ch_bw),
        .bin_valid     (bin_valid),
        .bin_info      (bin_info)
    );

    always #2 clk = ~clk;                     // 4 ns period

    initial begin : enable_gen
        void'($urandom(32'hd799d08a));
        clk_en = 1'b1;
        forever begin
            @(negedge clk);
            clk_en <= ($urandom % 4) != 0;    // enabled about 3 cycles in 4
        end
    end

    function automatic int table_nfft(input int code);
        case (code)
            0: return 11;
            1: return 10;
            2: return 9;
            3: return 11;
            4: return 12;
            default: return 11;
        endcase
    endfunction

    function automatic int table_nsc(input int code);
        case (code)
            0: return 1200;
            1: return 600;
            2: return 300;
            3: return 900;
            4: return 3276;
            default: return 1200;
        endcase
    endfunction

    function automatic ofdm_pkg::scale_t table_scale(input int code);
        return (code == 2) ? `SCALE_5M : `SCALE_DEFAULT;   // forward fft instance
    endfunction

    // dc at 0, positive band 1..h, negative band N-h..N-1
    function automatic void expected_mapping(input int b, input int n, input int h,
                                             output bit occ, output int idx);
        occ = 1'b0;
        idx = 0;
        if (b >= 1 && b <= h) begin
            occ = 1'b1;
            idx = h + b - 1;
        end else if (b != 0 && b >= n - h) begin
            occ = 1'b1;
            idx = b - (n - h);
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAILED t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    endtask

    always @(posedge clk) begin : ref_model
        int nxt_phase;
        int nxt_bin;
        int n_use;
        int nsc_use;
        bit occ;
        int idx;
        if (reset) begin
            phase     <= 0;
            car_prev  <= 1'b0;
            code_lat  <= '0;
            exp_done  <= 1'b0;
            exp_bw    <= '0;
            exp_nfft  <= ofdm_pkg::nfft_t'(`CFG_DEFAULT_NFFT);
            exp_nsc   <= ofdm_pkg::nsc_t'(`CFG_DEFAULT_NSC);
            exp_scale <= `SCALE_DEFAULT;
            exp_valid <= 1'b0;
            exp_bin   <= 0;
            sweep_n   <= 0;
            sweep_nsc <= 0;
        end else if (clk_en) begin
            nxt_phase = phase;
            if (phase == 0) begin
                if (car_en && !car_prev) begin
                    nxt_phase = 1;                  // this edge is E0
                    code_lat <= ch_bw;
                end
            end else if (phase == 4) begin
                nxt_phase = 0;                      // done seen so back to idle
            end else begin
                nxt_phase = phase + 1;              // edges during update ignored
            end
            phase    <= nxt_phase;
            car_prev <= car_en;
            exp_done <= (nxt_phase == 4);
            if (nxt_phase == 3) begin
                exp_bw   <= code_lat;
                exp_nfft <= ofdm_pkg::nfft_t'(table_nfft(code_lat));  // nfft_we commit
            end
            if (nxt_phase == 4) begin
                exp_nsc   <= ofdm_pkg::nsc_t'(table_nsc(code_lat));   // ctrl_we commit
                exp_scale <= table_scale(code_lat);
            end
            nxt_bin = exp_bin;
            n_use   = sweep_n;
            nsc_use = sweep_nsc;
            if (!exp_valid && sym_start) begin
                n_use   = 1 << exp_nfft;            // live config at start
                nsc_use = exp_nsc;
                nxt_bin = 0;
                sweep_n   <= n_use;
                sweep_nsc <= nsc_use;
                exp_valid <= 1'b1;
            end else if (exp_valid) begin
                if (exp_bin == sweep_n - 1) begin
                    exp_valid <= 1'b0;
                end else begin
                    nxt_bin = exp_bin + 1;
                end
            end
            expected_mapping(nxt_bin, n_use, nsc_use / 2, occ, idx);
            exp_bin   <= nxt_bin;
            exp_occ   <= occ;
            exp_idx   <= ofdm_pkg::nsc_t'(idx);
            exp_first <= (nxt_bin == 0);
            exp_last  <= (nxt_bin == n_use - 1);
        end
    end

    // cycle accurate compare against the model on enabled edges
    done_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> update_done == exp_done)
        else report_mismatch("update_done", $sampled(exp_done), $sampled(update_done));
    bw_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> current_ch_bw == exp_bw)
        else report_mismatch("current_ch_bw", $sampled(exp_bw), $sampled(current_ch_bw));
    nfft_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> fft_cfg.nfft == exp_nfft)
        else report_mismatch("fft_cfg.nfft", $sampled(exp_nfft), $sampled(fft_cfg.nfft));
    scale_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> fft_cfg.scale_sch == exp_scale)
        else report_mismatch("fft_cfg.scale_sch", $sampled(exp_scale),
                             $sampled(fft_cfg.scale_sch));
    dir_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> fft_cfg.fwd_inv == 1'b1)
        else report_mismatch("fft_cfg.fwd_inv", 1, $sampled(fft_cfg.fwd_inv));
    valid_check: assert property (@(posedge clk) disable iff (reset)
        clk_en |-> bin_valid == exp_valid)
        else report_mismatch("bin_valid", $sampled(exp_valid), $sampled(bin_valid));
    bin_check: assert property (@(posedge clk) disable iff (reset)
        clk_en && exp_valid |-> bin_info.bin == exp_bin)
        else report_mismatch("bin_info.bin", $sampled(exp_bin), $sampled(bin_info.bin));
    occ_check: assert property (@(posedge clk) disable iff (reset)
        clk_en && exp_valid |-> bin_info.occupied == exp_occ)
        else report_mismatch("bin_info.occupied", $sampled(exp_occ),
                             $sampled(bin_info.occupied));
    idx_check: assert property (@(posedge clk) disable iff (reset)
        clk_en && exp_valid |-> bin_info.sc_index == exp_idx)
        else report_mismatch("bin_info.sc_index", $sampled(exp_idx),
                             $sampled(bin_info.sc_index));
    first_check: assert property (@(posedge clk) disable iff (reset)
        clk_en && exp_valid |-> bin_info.first == exp_first)
        else report_mismatch("bin_info.first", $sampled(exp_first), $sampled(bin_info.first));
    last_check: assert property (@(posedge clk) disable iff (reset)
        clk_en && exp_valid |-> bin_info.last == exp_last)
        else report_mismatch("bin_info.last", $sampled(exp_last), $sampled(bin_info.last));

    // per sweep totals of bins, occupied bins and distinct indices
    always @(posedge clk) begin : sweep_audit
        if (reset || (clk_en && bin_valid && bin_info.last)) begin
            if (!reset) begin
                assert (bin_count + 1 == sweep_n)
                    else report_mismatch("valid bin count", sweep_n, bin_count + 1);
                assert (occ_count + bin_info.occupied == sweep_nsc)
                    else report_mismatch("occupied count", sweep_nsc,
                                         occ_count + bin_info.occupied);
                sweeps_done++;
            end
            foreach (seen[i]) begin
                seen[i] = 1'b0;
            end
            occ_count = 0;
            bin_count = 0;
        end else if (clk_en && bin_valid) begin
            bin_count++;
            if (bin_info.occupied) begin
                assert (bin_info.sc_index < sweep_nsc && !seen[bin_info.sc_index]) else begin
                    errors++;
                    $display("sc_index %0d out of range or repeated at t=%0t",
                             bin_info.sc_index, $time);
                end
                if (bin_info.sc_index < 4096) seen[bin_info.sc_index] = 1'b1;
                occ_count++;
            end
        end
    end

    // done pulses as seen on enabled edges
    always @(posedge clk) begin : done_count
        if (!reset && clk_en && update_done) begin
            updates_done++;
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run timed out after %0d cycles, errors so far %0d", cycles, errors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic wait_enabled_edge();
        @(posedge clk);
        while (!clk_en) @(posedge clk);
    endtask

    task automatic check_reset_values();
        assert (update_done == 1'b0) else report_mismatch("update_done", 0, update_done);
        assert (bin_valid == 1'b0) else report_mismatch("bin_valid", 0, bin_valid);
        assert (current_ch_bw == '0) else report_mismatch("current_ch_bw", 0, current_ch_bw);
        assert (fft_cfg == {1'b1, `SCALE_DEFAULT, 5'd11})
            else report_mismatch("fft_cfg", {1'b1, `SCALE_DEFAULT, 5'd11}, fft_cfg);
    endtask

    // car_en low then high; optional second edge at E2 that must be ignored
    task automatic run_update(input int code, input bit second_edge);
        int waited;
        @(negedge clk);
        ch_bw  = ofdm_pkg::bw_t'(code);
        car_en = 1'b0;
        repeat (2) wait_enabled_edge();
        @(negedge clk);
        car_en = 1'b1;
        wait_enabled_edge();                  // E0
        if (second_edge) begin
            @(negedge clk);
            car_en = 1'b0;
            wait_enabled_edge();              // E1 sees low
            @(negedge clk);
            car_en = 1'b1;
            wait_enabled_edge();              // E2 sees a new rise
        end
        waited = 0;
        @(negedge clk);
        while (!update_done && waited < 20) begin
            wait_enabled_edge();
            @(negedge clk);
            waited++;
        end
        assert (update_done) else begin
            errors++;
            $display("update_done never arrived for code %0d", code);
        end
    endtask

    task automatic run_sweep(input bit extra_start);
        int waited;
        @(negedge clk);
        sym_start = 1'b1;
        wait_enabled_edge();
        @(negedge clk);
        sym_start = 1'b0;
        waited = 0;
        while (!(bin_valid && bin_info.last) && waited < 6000) begin
            wait_enabled_edge();
            @(negedge clk);
            waited++;
            if (extra_start) sym_start = (waited == 16);   // one enabled edge mid sweep
        end
        sym_start = 1'b0;
        assert (bin_valid && bin_info.last) else begin
            errors++;
            $display("sweep never reached its last bin");
        end
        wait_enabled_edge();
    endtask

    initial begin : stimulus
        reset     = 1'b1;
        car_en    = 1'b0;
        ch_bw     = '0;
        sym_start = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_reset_values();
        reset = 1'b0;
        for (int code = 0; code <= 5; code++) begin
            run_update(code, code == 2 || code == 5);
            run_sweep(code == 1 || code == 4);   // car_en stays high through the sweep
        end
        repeat (4) wait_enabled_edge();
        if (updates_done != 6) begin
            errors++;
            $display("saw %0d update_done pulses where 6 were expected", updates_done);
        end
        if (sweeps_done != 6) begin
            errors++;
            $display("saw %0d completed sweeps where 6 were expected", sweeps_done);
        end
        $display("errors %0d, updates %0d, sweeps %0d", errors, updates_done, sweeps_done);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/ofdm_pkg.sv
design/bw_update_ctrl.sv
design/fft_cfg_regs.sv
design/sc_mapper.sv
design/ofdm_bw_top.sv
dv/ofdm_bw_tb.sv
